//--- include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address and data word widths
`define ADDR_W    32
`define DATA_W    32

// data cache has 16 sets, instruction cache has 32 lines
`define D_INDEX_W 4
`define I_INDEX_W 5

// byte offset inside one word
`define OFFSET_W  2

// fixed by the 3-bit pseudo-LRU tree
`define D_WAYS    4

`endif

//--- src/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] word_t;

    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0] size_t;

    typedef logic [1:0] way_t;

    // bit 2 root, bit 1 over ways 0/1, bit 0 over ways 2/3
    typedef logic [2:0] plru_t;

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_WRITE_BACK,
        DC_REFILL
    } dc_state_t;

    typedef enum logic {
        IC_IDLE,
        IC_REFILL
    } ic_state_t;

    // current owner of the shared memory bus
    typedef enum logic [1:0] {
        NONE,
        DATA,
        INST
    } grant_t;

endpackage

//--- src/d_cache.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module d_cache import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_data_req,
    input  logic  cpu_data_wr,
    input  size_t cpu_data_size,
    input  addr_t cpu_data_addr,
    input  word_t cpu_data_wdata,
    output word_t cpu_data_rdata,
    output logic  cpu_data_addr_ok,
    output logic  cpu_data_data_ok,
    output logic  dc_mem_req,
    output logic  dc_mem_wr,
    output size_t dc_mem_size,
    output addr_t dc_mem_addr,
    output word_t dc_mem_wdata,
    input  word_t dc_mem_rdata,
    input  logic  dc_mem_addr_ok,
    input  logic  dc_mem_data_ok
);
    localparam int TAG_W = `ADDR_W - `D_INDEX_W - `OFFSET_W;
    localparam int SETS  = 1 << `D_INDEX_W;
    localparam int BYTES = `DATA_W / 8;

    logic [`D_INDEX_W-1:0] index;
    logic [TAG_W-1:0]      tag;

    logic             valid_q [SETS][`D_WAYS];
    logic             dirty_q [SETS][`D_WAYS];
    logic [TAG_W-1:0] tag_q   [SETS][`D_WAYS];
    word_t            block_q [SETS][`D_WAYS];
    plru_t            plru_q  [SETS];

    dc_state_t  state;
    logic       just_refilled;
    logic       addr_rcv;
    logic       hit;
    way_t       hit_way;
    way_t       victim;
    logic       idle_ready;
    logic       accept;
    logic       miss_start;
    logic       refill_done;
    logic [BYTES-1:0] mask;

    // request captured at the miss
    logic [`D_INDEX_W-1:0] miss_index;
    logic [TAG_W-1:0]      miss_tag;
    way_t                  miss_way;
    logic                  miss_wr;
    logic [BYTES-1:0]      miss_mask;
    word_t                 miss_wdata;

    function automatic way_t plru_victim(plru_t t);
        return t[2] ? {1'b1, t[0]} : {1'b0, t[1]};
    endfunction

    // point every node on the path away from the used way
    function automatic plru_t plru_touch(plru_t t, way_t w);
        plru_t r;
        r = t;
        r[2] = ~w[1];
        if (w[1])
            r[0] = ~w[0];
        else
            r[1] = ~w[0];
        return r;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [BYTES-1:0] m);
        word_t r;
        for (int b = 0; b < BYTES; b++) begin
            r[8*b +: 8] = m[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return r;
    endfunction

    assign index = cpu_data_addr[`D_INDEX_W+`OFFSET_W-1:`OFFSET_W];
    assign tag   = cpu_data_addr[`ADDR_W-1:`D_INDEX_W+`OFFSET_W];

    // all four ways compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `D_WAYS; w++) begin
            if (valid_q[index][w] && tag_q[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        case (cpu_data_size)
            2'd0:    mask = 4'b0001 << cpu_data_addr[`OFFSET_W-1:0];
            2'd1:    mask = cpu_data_addr[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
    end

    assign victim      = plru_victim(plru_q[index]);
    // the merge cycle after a refill takes no new request
    assign idle_ready  = (state == DC_IDLE) && !just_refilled;
    assign accept      = idle_ready && cpu_data_req && hit;
    assign miss_start  = idle_ready && cpu_data_req && !hit;
    assign refill_done = (state == DC_REFILL) && dc_mem_data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= DC_IDLE;
            just_refilled <= 1'b0;
            addr_rcv      <= 1'b0;
        end else begin
            just_refilled <= refill_done;
            if (state != DC_IDLE && dc_mem_data_ok)
                addr_rcv <= 1'b0;
            else if (dc_mem_req && dc_mem_addr_ok)
                addr_rcv <= 1'b1;
            case (state)
                DC_IDLE: begin
                    if (miss_start)
                        state <= dirty_q[index][victim] ? DC_WRITE_BACK : DC_REFILL;
                end
                DC_WRITE_BACK: begin
                    if (dc_mem_data_ok)
                        state <= DC_REFILL;
                end
                DC_REFILL: begin
                    if (dc_mem_data_ok)
                        state <= DC_IDLE;
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_index <= index;
            miss_tag   <= tag;
            miss_way   <= victim;
            miss_wr    <= cpu_data_wr;
            miss_mask  <= mask;
            miss_wdata <= cpu_data_wdata;
        end
    end

    // valid, dirty and replacement state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < `D_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
                plru_q[s] <= '0;
            end
        end else begin
            if (refill_done) begin
                valid_q[miss_index][miss_way] <= 1'b1;
                dirty_q[miss_index][miss_way] <= 1'b0;
            end else if (just_refilled && miss_wr) begin
                dirty_q[miss_index][miss_way] <= 1'b1;
            end else if (accept && cpu_data_wr) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
            if (just_refilled)
                plru_q[miss_index] <= plru_touch(plru_q[miss_index], miss_way);
            else if (accept)
                plru_q[index] <= plru_touch(plru_q[index], hit_way);
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[miss_index][miss_way]   <= miss_tag;
            block_q[miss_index][miss_way] <= dc_mem_rdata;
        end else if (just_refilled && miss_wr) begin
            block_q[miss_index][miss_way] <=
                merge_bytes(block_q[miss_index][miss_way], miss_wdata, miss_mask);
        end else if (accept && cpu_data_wr) begin
            block_q[index][hit_way] <=
                merge_bytes(block_q[index][hit_way], cpu_data_wdata, mask);
        end
    end

    assign cpu_data_rdata   = hit ? block_q[index][hit_way] : dc_mem_rdata;
    assign cpu_data_addr_ok = accept || (state == DC_REFILL && dc_mem_req && dc_mem_addr_ok);
    assign cpu_data_data_ok = accept || refill_done;

    assign dc_mem_req   = (state != DC_IDLE) && !addr_rcv;
    assign dc_mem_wr    = (state == DC_WRITE_BACK);
    // write-back and refill always move a full word
    assign dc_mem_size  = 2'd2;
    // old line address from the victim tag on write-back
    assign dc_mem_addr  = dc_mem_wr ?
                          {tag_q[miss_index][miss_way], miss_index, {`OFFSET_W{1'b0}}} :
                          {miss_tag, miss_index, {`OFFSET_W{1'b0}}};
    assign dc_mem_wdata = block_q[miss_index][miss_way];

endmodule

//--- src/i_cache.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module i_cache import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_inst_req,
    input  addr_t cpu_inst_addr,
    output word_t cpu_inst_rdata,
    output logic  cpu_inst_addr_ok,
    output logic  cpu_inst_data_ok,
    output logic  ic_mem_req,
    output addr_t ic_mem_addr,
    input  word_t ic_mem_rdata,
    input  logic  ic_mem_addr_ok,
    input  logic  ic_mem_data_ok
);
    localparam int TAG_W = `ADDR_W - `I_INDEX_W - `OFFSET_W;
    localparam int LINES = 1 << `I_INDEX_W;

    logic [`I_INDEX_W-1:0] index;
    logic [TAG_W-1:0]      tag;

    logic             valid_q [LINES];
    logic [TAG_W-1:0] tag_q   [LINES];
    word_t            data_q  [LINES];

    ic_state_t state;
    logic      addr_rcv;
    logic      hit;
    logic      lookup_ok;
    logic      refill_done;

    assign index = cpu_inst_addr[`I_INDEX_W+`OFFSET_W-1:`OFFSET_W];
    assign tag   = cpu_inst_addr[`ADDR_W-1:`I_INDEX_W+`OFFSET_W];

    assign hit         = valid_q[index] && tag_q[index] == tag;
    assign lookup_ok   = (state == IC_IDLE) && cpu_inst_req && hit;
    assign refill_done = (state == IC_REFILL) && ic_mem_data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IC_IDLE;
            addr_rcv <= 1'b0;
        end else begin
            if (ic_mem_data_ok)
                addr_rcv <= 1'b0;
            else if (ic_mem_req && ic_mem_addr_ok)
                addr_rcv <= 1'b1;
            case (state)
                IC_IDLE: begin
                    if (cpu_inst_req && !hit)
                        state <= IC_REFILL;
                end
                IC_REFILL: begin
                    if (ic_mem_data_ok)
                        state <= IC_IDLE;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (refill_done) begin
            valid_q[index] <= 1'b1;
        end
    end

    // address is held by the core until data_ok, so install at the current index
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[index]  <= tag;
            data_q[index] <= ic_mem_rdata;
        end
    end

    // refill word is forwarded straight to the core
    assign cpu_inst_rdata   = (state == IC_IDLE) ? data_q[index] : ic_mem_rdata;
    assign cpu_inst_addr_ok = lookup_ok || (state == IC_REFILL && ic_mem_req && ic_mem_addr_ok);
    assign cpu_inst_data_ok = lookup_ok || refill_done;

    assign ic_mem_req  = (state == IC_REFILL) && !addr_rcv;
    assign ic_mem_addr = {cpu_inst_addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   dc_mem_req,
    input  logic   dc_mem_wr,
    input  size_t  dc_mem_size,
    input  addr_t  dc_mem_addr,
    input  word_t  dc_mem_wdata,
    output word_t  dc_mem_rdata,
    output logic   dc_mem_addr_ok,
    output logic   dc_mem_data_ok,
    input  logic   ic_mem_req,
    input  addr_t  ic_mem_addr,
    output word_t  ic_mem_rdata,
    output logic   ic_mem_addr_ok,
    output logic   ic_mem_data_ok,
    output logic   mem_req,
    output logic   mem_wr,
    output size_t  mem_size,
    output addr_t  mem_addr,
    output word_t  mem_wdata,
    input  word_t  mem_rdata,
    input  logic   mem_addr_ok,
    input  logic   mem_data_ok
);
    grant_t grant_q;
    grant_t owner;

    // new grant only while idle, data cache first
    always_comb begin
        owner = grant_q;
        if (grant_q == NONE) begin
            if (dc_mem_req)
                owner = DATA;
            else if (ic_mem_req)
                owner = INST;
        end
    end

    // held for the whole transfer, released after data_ok
    always_ff @(posedge clk) begin
        if (rst)
            grant_q <= NONE;
        else if (owner != NONE && !mem_data_ok)
            grant_q <= owner;
        else
            grant_q <= NONE;
    end

    always_comb begin
        mem_req        = 1'b0;
        mem_wr         = 1'b0;
        mem_size       = 2'd2;
        mem_addr       = '0;
        mem_wdata      = '0;
        dc_mem_rdata   = '0;
        dc_mem_addr_ok = 1'b0;
        dc_mem_data_ok = 1'b0;
        ic_mem_rdata   = '0;
        ic_mem_addr_ok = 1'b0;
        ic_mem_data_ok = 1'b0;
        case (owner)
            DATA: begin
                mem_req        = dc_mem_req;
                mem_wr         = dc_mem_wr;
                mem_size       = dc_mem_size;
                mem_addr       = dc_mem_addr;
                mem_wdata      = dc_mem_wdata;
                dc_mem_rdata   = mem_rdata;
                dc_mem_addr_ok = mem_addr_ok;
                dc_mem_data_ok = mem_data_ok;
            end
            // fetch goes out as a plain word read
            INST: begin
                mem_req        = ic_mem_req;
                mem_addr       = ic_mem_addr;
                ic_mem_rdata   = mem_rdata;
                ic_mem_addr_ok = mem_addr_ok;
                ic_mem_data_ok = mem_data_ok;
            end
            default: ;
        endcase
    end

endmodule

//--- src/cache_sys.sv
`timescale 1ns/1ps

module cache_sys import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_data_req,
    input  logic  cpu_data_wr,
    input  size_t cpu_data_size,
    input  addr_t cpu_data_addr,
    input  word_t cpu_data_wdata,
    output word_t cpu_data_rdata,
    output logic  cpu_data_addr_ok,
    output logic  cpu_data_data_ok,
    input  logic  cpu_inst_req,
    input  addr_t cpu_inst_addr,
    output word_t cpu_inst_rdata,
    output logic  cpu_inst_addr_ok,
    output logic  cpu_inst_data_ok,
    output logic  mem_req,
    output logic  mem_wr,
    output size_t mem_size,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok
);
    // data cache side of the arbiter
    logic  dc_mem_req;
    logic  dc_mem_wr;
    size_t dc_mem_size;
    addr_t dc_mem_addr;
    word_t dc_mem_wdata;
    word_t dc_mem_rdata;
    logic  dc_mem_addr_ok;
    logic  dc_mem_data_ok;

    // instruction cache side
    logic  ic_mem_req;
    addr_t ic_mem_addr;
    word_t ic_mem_rdata;
    logic  ic_mem_addr_ok;
    logic  ic_mem_data_ok;

    d_cache u_d_cache (.*);

    i_cache u_i_cache (.*);

    mem_arbiter u_mem_arbiter (.*);

endmodule

//--- tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // released on a falling edge after 16 cycles
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tests/cache_sys_checker.sv
`timescale 1ns/1ps

module cache_sys_checker (
    input logic clk,
    input logic rst,
    input logic mem_req,
    input logic mem_addr_ok,
    input logic mem_data_ok,
    input logic dc_mem_data_ok,
    input logic ic_mem_data_ok,
    input logic cpu_data_req,
    input logic cpu_data_data_ok
);
    int fail_count = 0;

    // a bus request may not be withdrawn before it is accepted
    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req)
        else begin
            fail_count++;
            $error("mem_req dropped before mem_addr_ok");
        end

    // each memory data_ok goes back to the bus owner only
    one_data_ok: assert property (@(posedge clk) disable iff (rst)
        mem_data_ok |-> (dc_mem_data_ok ^ ic_mem_data_ok))
        else begin
            fail_count++;
            $error("mem_data_ok not routed to exactly one cache");
        end

    data_ok_with_req: assert property (@(posedge clk) disable iff (rst)
        cpu_data_data_ok |-> cpu_data_req)
        else begin
            fail_count++;
            $error("cpu_data_data_ok without cpu_data_req");
        end

endmodule

bind cache_sys cache_sys_checker checker0 (
    .clk(clk),
    .rst(rst),
    .mem_req(mem_req),
    .mem_addr_ok(mem_addr_ok),
    .mem_data_ok(mem_data_ok),
    .dc_mem_data_ok(dc_mem_data_ok),
    .ic_mem_data_ok(ic_mem_data_ok),
    .cpu_data_req(cpu_data_req),
    .cpu_data_data_ok(cpu_data_data_ok)
);

//--- tests/cache_sys_tb.sv
`timescale 1ns/1ps

module cache_sys_tb import cache_pkg::*; ();

    localparam int N_RAND = 40;
    // tests 1 to 4 in order, then the random data and fetch streams of test 5
    localparam int N_OPS = 2 + 14 + 10 + 10 + 2 * N_RAND;

    logic  clk;
    logic  rst;
    logic  cpu_data_req;
    logic  cpu_data_wr;
    size_t cpu_data_size;
    addr_t cpu_data_addr;
    word_t cpu_data_wdata;
    word_t cpu_data_rdata;
    logic  cpu_data_addr_ok;
    logic  cpu_data_data_ok;
    logic  cpu_inst_req;
    addr_t cpu_inst_addr;
    word_t cpu_inst_rdata;
    logic  cpu_inst_addr_ok;
    logic  cpu_inst_data_ok;
    logic  mem_req;
    logic  mem_wr;
    size_t mem_size;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_addr_ok;
    logic  mem_data_ok;

    // 16 KB of memory indexed by address bits 13:2
    word_t mem_img [4096];
    word_t ref_img [4096];
    word_t data_exp [$];
    word_t inst_exp [$];

    logic [31:0] lfsr = 32'hcd2a;
    int    errors = 0;
    int    checks = 0;
    int    bus_count = 0;
    int    wr_count = 0;
    addr_t last_addr;
    addr_t last_wr_addr;
    word_t last_wr_data;

    clk_gen clk_gen0 (.clk(clk), .rst(rst));

    cache_sys dut0 (.*);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], ~a[31:16]} ^ a ^ 32'h6b3c_91e5;
    endfunction

    // byte lanes written by a store of the given size
    function automatic logic [3:0] byte_enables(size_t sz, logic [1:0] off);
        logic [3:0] be;
        for (int b = 0; b < 4; b++) begin
            case (sz)
                2'd0:    be[b] = (b == off);
                2'd1:    be[b] = (b / 2 == off / 2);
                default: be[b] = 1'b1;
            endcase
        end
        return be;
    endfunction

    function automatic word_t ref_access(addr_t a, logic wr, size_t sz, word_t wd);
        logic [3:0] be;
        be = byte_enables(sz, a[1:0]);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    ref_img[a[13:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end
        return ref_img[a[13:2]];
    endfunction

    task automatic report_mismatch(string msg);
        errors++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    task automatic data_op(input logic wr, input size_t sz, input addr_t a, input word_t wd);
        word_t exp;
        int    addr_oks;
        exp = ref_access(a, wr, sz, wd);
        addr_oks = 0;
        if (!wr)
            data_exp.push_back(exp);
        @(negedge clk);
        cpu_data_req   = 1'b1;
        cpu_data_wr    = wr;
        cpu_data_size  = sz;
        cpu_data_addr  = a;
        cpu_data_wdata = wd;
        do begin
            @(posedge clk);
            if (cpu_data_addr_ok === 1'b1)
                addr_oks++;
        end while (cpu_data_data_ok !== 1'b1);
        if (addr_oks != 1)
            report_mismatch($sformatf("data access 0x%h saw %0d addr_ok strobes, expected 1",
                                      a, addr_oks));
        @(negedge clk);
        cpu_data_req = 1'b0;
    endtask

    task automatic fetch(input addr_t a);
        int addr_oks;
        addr_oks = 0;
        inst_exp.push_back(ref_img[a[13:2]]);
        @(negedge clk);
        cpu_inst_req  = 1'b1;
        cpu_inst_addr = a;
        do begin
            @(posedge clk);
            if (cpu_inst_addr_ok === 1'b1)
                addr_oks++;
        end while (cpu_inst_data_ok !== 1'b1);
        if (addr_oks != 1)
            report_mismatch($sformatf("fetch 0x%h saw %0d addr_ok strobes, expected 1",
                                      a, addr_oks));
        @(negedge clk);
        cpu_inst_req = 1'b0;
    endtask

    // one word per transfer with 0 to 3 extra cycles before each strobe
    task automatic serve_transfer();
        addr_t      a;
        logic       w;
        word_t      wd;
        logic [3:0] be;
        a  = mem_addr;
        w  = mem_wr;
        wd = mem_wdata;
        be = byte_enables(mem_size, a[1:0]);
        @(negedge clk);
        repeat (int'(rand_bits(2))) @(negedge clk);
        mem_addr_ok = 1'b1;
        @(negedge clk);
        mem_addr_ok = 1'b0;
        repeat (int'(rand_bits(2))) @(negedge clk);
        if (w) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    mem_img[a[13:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end else begin
            mem_rdata = mem_img[a[13:2]];
        end
        mem_data_ok = 1'b1;
        @(negedge clk);
        mem_data_ok = 1'b0;
    endtask

    initial begin
        mem_rdata   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req === 1'b1)
                serve_transfer();
        end
    end

    // bus traffic log taken when a request is accepted
    always @(posedge clk) begin
        if (!rst && mem_req && mem_addr_ok) begin
            bus_count <= bus_count + 1;
            last_addr <= mem_addr;
            if (mem_wr) begin
                wr_count     <= wr_count + 1;
                last_wr_addr <= mem_addr;
                last_wr_data <= mem_wdata;
            end
        end
    end

    always @(posedge clk) begin
        word_t exp;
        if (!rst && cpu_data_req && cpu_data_data_ok && !cpu_data_wr) begin
            checks++;
            if (data_exp.size() == 0) begin
                errors++;
                $display("data port answered a load that was never issued");
            end else begin
                exp = data_exp.pop_front();
                if (cpu_data_rdata !== exp)
                    report_mismatch($sformatf("load 0x%h returned %h, expected %h",
                                              cpu_data_addr, cpu_data_rdata, exp));
            end
        end
        if (!rst && cpu_inst_req && cpu_inst_data_ok) begin
            checks++;
            if (inst_exp.size() == 0) begin
                errors++;
                $display("instruction port answered a fetch that was never issued");
            end else begin
                exp = inst_exp.pop_front();
                if (cpu_inst_rdata !== exp)
                    report_mismatch($sformatf("fetch 0x%h returned %h, expected %h",
                                              cpu_inst_addr, cpu_inst_rdata, exp));
            end
        end
    end

    initial begin
        repeat (16 + N_OPS * 64) @(posedge clk);
        $display("watchdog expired with operations still pending");
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.checker0.fail_count);
        $display("tests failed");
        $finish;
    end

    initial begin
        int    n;
        addr_t a;
        cpu_data_req   = 1'b0;
        cpu_data_wr    = 1'b0;
        cpu_data_size  = 2'd2;
        cpu_data_addr  = '0;
        cpu_data_wdata = '0;
        cpu_inst_req   = 1'b0;
        cpu_inst_addr  = '0;
        for (int i = 0; i < 4096; i++) begin
            mem_img[i] = fill_word(addr_t'(i) << 2);
            ref_img[i] = mem_img[i];
        end
        wait (rst === 1'b0);

        // load miss, then the same load as a hit
        n = bus_count;
        data_op(1'b0, 2'd2, 32'h0100, '0);
        if (bus_count != n + 1)
            report_mismatch("first load after reset did not refill from memory");
        data_op(1'b0, 2'd2, 32'h0100, '0);
        if (bus_count != n + 1)
            report_mismatch("repeated load went to memory again");

        // every size at every legal offset of one word
        for (int off = 0; off < 4; off++) begin
            data_op(1'b1, 2'd0, 32'h0104 + addr_t'(off), rand_bits(32));
            data_op(1'b0, 2'd2, 32'h0104, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            data_op(1'b1, 2'd1, 32'h0104 + addr_t'(off), rand_bits(32));
            data_op(1'b0, 2'd2, 32'h0104, '0);
        end
        data_op(1'b1, 2'd2, 32'h0104, rand_bits(32));
        data_op(1'b0, 2'd2, 32'h0104, '0);

        // set 3 fills ways 0, 2, 1, 3, so the tree points back at the first line
        for (int k = 0; k < 4; k++)
            data_op(1'b1, 2'd2, 32'h040c + addr_t'(k) * 32'h40, 32'h3c00_0000 + k);
        n = wr_count;
        data_op(1'b1, 2'd2, 32'h050c, 32'h3c00_0004);
        if (wr_count != n + 1)
            report_mismatch("fifth store in a full set did not write back one line");
        else if (last_wr_addr != 32'h040c || last_wr_data != ref_img[32'h040c >> 2])
            report_mismatch($sformatf("write-back carried %h / %h, expected 040c / %h",
                                      last_wr_addr, last_wr_data, ref_img[32'h040c >> 2]));
        for (int k = 0; k < 5; k++)
            data_op(1'b0, 2'd2, 32'h040c + addr_t'(k) * 32'h40, '0);

        // touching the first line of set 6 leaves the second one as victim
        for (int k = 0; k < 4; k++)
            data_op(1'b0, 2'd2, 32'h0818 + addr_t'(k) * 32'h40, '0);
        data_op(1'b0, 2'd2, 32'h0818, '0);
        n = bus_count;
        data_op(1'b0, 2'd2, 32'h0918, '0);
        data_op(1'b0, 2'd2, 32'h0818, '0);
        data_op(1'b0, 2'd2, 32'h0898, '0);
        data_op(1'b0, 2'd2, 32'h08d8, '0);
        if (bus_count != n + 1)
            report_mismatch("miss in set 6 replaced a line other than the predicted one");
        data_op(1'b0, 2'd2, 32'h0858, '0);
        if (bus_count != n + 2 || last_addr != 32'h0858)
            report_mismatch($sformatf("predicted victim 0858 did not miss, last bus addr %h",
                                      last_addr));

        // random data traffic against fetches from a separate region
        fork
            begin
                logic  wr;
                size_t sz;
                for (int i = 0; i < N_RAND; i++) begin
                    wr = 1'(rand_bits(1));
                    sz = size_t'(rand_bits(2));
                    if (sz == 2'd3)
                        sz = 2'd2;
                    a = addr_t'(rand_bits(10)) << 2;
                    if (sz == 2'd0)
                        a = a | addr_t'(rand_bits(2));
                    else if (sz == 2'd1)
                        a = a | (addr_t'(rand_bits(1)) << 1);
                    data_op(wr, sz, a, rand_bits(32));
                end
            end
            begin
                for (int i = 0; i < N_RAND; i++)
                    fetch(32'h2000 + (addr_t'(rand_bits(7)) << 2));
            end
        join

        repeat (2) @(posedge clk);
        if (data_exp.size() != 0 || inst_exp.size() != 0) begin
            errors++;
            $display("some issued accesses never got data_ok");
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.checker0.fail_count);
        if (errors == 0 && dut0.checker0.fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- cache_sys.f
+incdir+include
src/cache_pkg.sv
src/d_cache.sv
src/i_cache.sv
src/mem_arbiter.sv
src/cache_sys.sv
tests/clk_gen.sv
tests/cache_sys_checker.sv
tests/cache_sys_tb.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_sys_tb \
		-f cache_sys.f -Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim +verilator+error+limit+100 | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
